/* src/croc_lite_pkg.sv */
// Shared bus types, address map and register offsets, referenced by scoped names in the design
package croc_lite_pkg;

  // ----------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [1:0]  sel_t;

  // Subordinate select codes
  localparam sel_t SelSram    = 2'd0;
  localparam sel_t SelSocCtrl = 2'd1;
  localparam sel_t SelGpio    = 2'd2;
  localparam sel_t SelError   = 2'd3;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam addr_t SramBaseAddr    = 32'h1000_0000;
  localparam addr_t SocCtrlBaseAddr = 32'h0300_0000;
  localparam addr_t GpioBaseAddr    = 32'h0300_5000;

  // Every peripheral gets a 4 KiB window
  localparam addr_t PeriphSpan = 32'h0000_1000;

  // Returned on any access outside the map
  localparam data_t ErrRspData = 32'hBADC_AB1E;

  // ----------------------------------------------------------
  // Register offsets within a peripheral window
  // ----------------------------------------------------------
  // SoC control
  localparam addr_t BootAddrOffset = 32'h0;
  localparam addr_t FetchEnOffset  = 32'h4;

  // GPIO
  localparam addr_t GpioDirOffset = 32'h0;
  localparam addr_t GpioOutOffset = 32'h4;
  localparam addr_t GpioInOffset  = 32'h8;

endpackage

/* src/obi_bus_if.sv */
// One OBI-style request/response bus, connected through its mgr and sbr modports
`timescale 1ns/10ps

interface obi_bus_if;

  // Address phase, driven by the manager
  logic                 req;
  croc_lite_pkg::addr_t addr;
  logic                 we;
  croc_lite_pkg::be_t   be;
  croc_lite_pkg::data_t wdata;

  // Grant and response phase, driven by the subordinate
  logic                 gnt;
  logic                 rvalid;
  croc_lite_pkg::data_t rdata;
  logic                 err;

  modport mgr (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport sbr (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

/* src/bus_demux.sv */
// Address decoder and demultiplexer from the external manager to SRAM and peripherals
`timescale 1ns/10ps

module bus_demux #(
  parameter int unsigned SramNumWords = 1024
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  obi_bus_if.sbr mgr_bus,
  obi_bus_if.mgr sram_bus,
  obi_bus_if.mgr soc_ctrl_bus,
  obi_bus_if.mgr gpio_bus
);

  localparam croc_lite_pkg::addr_t SramSpan = croc_lite_pkg::addr_t'(SramNumWords * 4);

  croc_lite_pkg::sel_t sel_d;
  croc_lite_pkg::sel_t sel_q;
  logic                accept;
  logic                err_rsp_q;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  // Offset from each base wraps around, so one compare per window
  always_comb begin
    sel_d = croc_lite_pkg::SelError;
    if ((mgr_bus.addr - croc_lite_pkg::SramBaseAddr) < SramSpan) begin
      sel_d = croc_lite_pkg::SelSram;
    end else if ((mgr_bus.addr - croc_lite_pkg::SocCtrlBaseAddr) <
                 croc_lite_pkg::PeriphSpan) begin
      sel_d = croc_lite_pkg::SelSocCtrl;
    end else if ((mgr_bus.addr - croc_lite_pkg::GpioBaseAddr) <
                 croc_lite_pkg::PeriphSpan) begin
      sel_d = croc_lite_pkg::SelGpio;
    end
  end

  // ----------------------------------------------------------
  // Request fan-out
  // ----------------------------------------------------------
  // Only req is qualified by the select
  assign sram_bus.req       = mgr_bus.req && (sel_d == croc_lite_pkg::SelSram);
  assign sram_bus.addr      = mgr_bus.addr;
  assign sram_bus.we        = mgr_bus.we;
  assign sram_bus.be        = mgr_bus.be;
  assign sram_bus.wdata     = mgr_bus.wdata;

  assign soc_ctrl_bus.req   = mgr_bus.req && (sel_d == croc_lite_pkg::SelSocCtrl);
  assign soc_ctrl_bus.addr  = mgr_bus.addr;
  assign soc_ctrl_bus.we    = mgr_bus.we;
  assign soc_ctrl_bus.be    = mgr_bus.be;
  assign soc_ctrl_bus.wdata = mgr_bus.wdata;

  assign gpio_bus.req       = mgr_bus.req && (sel_d == croc_lite_pkg::SelGpio);
  assign gpio_bus.addr      = mgr_bus.addr;
  assign gpio_bus.we        = mgr_bus.we;
  assign gpio_bus.be        = mgr_bus.be;
  assign gpio_bus.wdata     = mgr_bus.wdata;

  // Unmapped accesses are always granted
  always_comb begin
    case (sel_d)
      croc_lite_pkg::SelSram:    mgr_bus.gnt = sram_bus.gnt;
      croc_lite_pkg::SelSocCtrl: mgr_bus.gnt = soc_ctrl_bus.gnt;
      croc_lite_pkg::SelGpio:    mgr_bus.gnt = gpio_bus.gnt;
      default:                   mgr_bus.gnt = 1'b1;
    endcase
  end

  assign accept = mgr_bus.req && mgr_bus.gnt;

  // Target of the access now in its response phase
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q     <= croc_lite_pkg::SelError;
      err_rsp_q <= 1'b0;
    end else begin
      err_rsp_q <= accept && (sel_d == croc_lite_pkg::SelError);
      if (accept) begin
        sel_q <= sel_d;
      end
    end
  end

  // ----------------------------------------------------------
  // Response mux
  // ----------------------------------------------------------
  always_comb begin
    case (sel_q)
      croc_lite_pkg::SelSram: begin
        mgr_bus.rvalid = sram_bus.rvalid;
        mgr_bus.rdata  = sram_bus.rdata;
        mgr_bus.err    = sram_bus.err;
      end
      croc_lite_pkg::SelSocCtrl: begin
        mgr_bus.rvalid = soc_ctrl_bus.rvalid;
        mgr_bus.rdata  = soc_ctrl_bus.rdata;
        mgr_bus.err    = soc_ctrl_bus.err;
      end
      croc_lite_pkg::SelGpio: begin
        mgr_bus.rvalid = gpio_bus.rvalid;
        mgr_bus.rdata  = gpio_bus.rdata;
        mgr_bus.err    = gpio_bus.err;
      end
      default: begin
        // Error response generated here
        mgr_bus.rvalid = err_rsp_q;
        mgr_bus.rdata  = croc_lite_pkg::ErrRspData;
        mgr_bus.err    = err_rsp_q;
      end
    endcase
  end

endmodule

/* src/sram_bank.sv */
// Single-port SRAM bank on the bus with byte enables and one-cycle read latency
`timescale 1ns/10ps

module sram_bank #(
  parameter int unsigned SramNumWords = 1024
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  obi_bus_if.sbr bus
);

  localparam int unsigned IdxWidth = $clog2(SramNumWords);
  localparam int unsigned NumBytes = $bits(croc_lite_pkg::be_t);

  croc_lite_pkg::data_t mem_q [SramNumWords];
  croc_lite_pkg::data_t rdata_q;
  logic [IdxWidth-1:0]  word_idx;
  logic                 rvalid_q;

  // Word index sits above the two byte-offset bits
  assign word_idx = bus.addr[2 +: IdxWidth];

  // Storage and read data register
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < NumBytes; b++) begin
          if (bus.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

/* src/soc_ctrl_regs.sv */
// SoC control registers holding the boot address and fetch enable
`timescale 1ns/10ps

module soc_ctrl_regs (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 fetch_en_i,
  obi_bus_if.sbr               bus,
  output croc_lite_pkg::addr_t boot_addr_o,
  output logic                 fetch_enable_o
);

  localparam int unsigned NumBytes = $bits(croc_lite_pkg::be_t);

  croc_lite_pkg::addr_t reg_off;
  croc_lite_pkg::addr_t boot_addr_q;
  croc_lite_pkg::data_t rdata_d;
  croc_lite_pkg::data_t rdata_q;
  logic                 fetchen_q;
  logic                 rvalid_q;

  assign reg_off = bus.addr & (croc_lite_pkg::PeriphSpan - 1);

  // ----------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= croc_lite_pkg::SramBaseAddr;
      fetchen_q   <= 1'b0;
    end else if (bus.req && bus.we) begin
      if (reg_off == croc_lite_pkg::BootAddrOffset) begin
        for (int b = 0; b < NumBytes; b++) begin
          if (bus.be[b]) begin
            boot_addr_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
      // Enable bit lives in the lowest byte
      if (reg_off == croc_lite_pkg::FetchEnOffset && bus.be[0]) begin
        fetchen_q <= bus.wdata[0];
      end
    end
  end

  // Unknown offsets read zero
  always_comb begin
    rdata_d = '0;
    if (reg_off == croc_lite_pkg::BootAddrOffset) begin
      rdata_d = boot_addr_q;
    end else if (reg_off == croc_lite_pkg::FetchEnOffset) begin
      rdata_d[0] = fetchen_q;
    end
  end

  // ----------------------------------------------------------
  // Response
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign boot_addr_o    = boot_addr_q;
  // External pin can also start the fetch
  assign fetch_enable_o = fetchen_q | fetch_en_i;

endmodule

/* src/gpio_regs.sv */
// GPIO block with direction and output registers and synchronized pin inputs
`timescale 1ns/10ps

module gpio_regs #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  obi_bus_if.sbr               bus,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o
);

  croc_lite_pkg::addr_t reg_off;
  croc_lite_pkg::data_t rdata_d;
  croc_lite_pkg::data_t rdata_q;
  logic [GpioCount-1:0] wmask;
  logic [GpioCount-1:0] wbits;
  logic [GpioCount-1:0] dir_q;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] sync_q;
  logic [GpioCount-1:0] in_q;
  logic                 rvalid_q;

  assign reg_off = bus.addr & (croc_lite_pkg::PeriphSpan - 1);
  assign wbits   = bus.wdata[GpioCount-1:0];

  // Per-pin mask from byte enables
  always_comb begin
    for (int i = 0; i < GpioCount; i++) begin
      wmask[i] = bus.be[i/8];
    end
  end

  // ----------------------------------------------------------
  // Registers and input synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q  <= '0;
      out_q  <= '0;
      sync_q <= '0;
      in_q   <= '0;
    end else begin
      sync_q <= gpio_i;
      in_q   <= sync_q;
      if (bus.req && bus.we && reg_off == croc_lite_pkg::GpioDirOffset) begin
        dir_q <= (dir_q & ~wmask) | (wbits & wmask);
      end
      if (bus.req && bus.we && reg_off == croc_lite_pkg::GpioOutOffset) begin
        out_q <= (out_q & ~wmask) | (wbits & wmask);
      end
    end
  end

  always_comb begin
    case (reg_off)
      croc_lite_pkg::GpioDirOffset: rdata_d = croc_lite_pkg::data_t'(dir_q);
      croc_lite_pkg::GpioOutOffset: rdata_d = croc_lite_pkg::data_t'(out_q);
      croc_lite_pkg::GpioInOffset:  rdata_d = croc_lite_pkg::data_t'(in_q);
      default:                      rdata_d = '0;
    endcase
  end

  // Response path
  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign gpio_o        = out_q;
  assign gpio_out_en_o = dir_q;

endmodule

/* src/croc_lite_domain.sv */
// Top level of the SoC bus domain with the external manager bus on plain ports
`timescale 1ns/10ps

module croc_lite_domain #(
  parameter int unsigned GpioCount    = 16,
  parameter int unsigned SramNumWords = 1024
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 fetch_en_i,

  // External manager
  input  logic                 req_i,
  input  croc_lite_pkg::addr_t addr_i,
  input  logic                 we_i,
  input  croc_lite_pkg::be_t   be_i,
  input  croc_lite_pkg::data_t wdata_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output croc_lite_pkg::data_t rdata_o,
  output logic                 err_o,

  output croc_lite_pkg::addr_t boot_addr_o,
  output logic                 fetch_enable_o,

  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o
);

  // ----------------------------------------------------------
  // Buses
  // ----------------------------------------------------------
  obi_bus_if mgr_bus ();
  obi_bus_if sram_bus ();
  obi_bus_if soc_ctrl_bus ();
  obi_bus_if gpio_bus ();

  assign mgr_bus.req   = req_i;
  assign mgr_bus.addr  = addr_i;
  assign mgr_bus.we    = we_i;
  assign mgr_bus.be    = be_i;
  assign mgr_bus.wdata = wdata_i;

  assign gnt_o    = mgr_bus.gnt;
  assign rvalid_o = mgr_bus.rvalid;
  assign rdata_o  = mgr_bus.rdata;
  assign err_o    = mgr_bus.err;

  // ----------------------------------------------------------
  // Decode and demux
  // ----------------------------------------------------------
  bus_demux #(
    .SramNumWords ( SramNumWords )
  ) i_bus_demux (
    .clk_i,
    .arst_n_i,
    .mgr_bus      ( mgr_bus.sbr      ),
    .sram_bus     ( sram_bus.mgr     ),
    .soc_ctrl_bus ( soc_ctrl_bus.mgr ),
    .gpio_bus     ( gpio_bus.mgr     )
  );

  // ----------------------------------------------------------
  // Memory
  // ----------------------------------------------------------
  sram_bank #(
    .SramNumWords ( SramNumWords )
  ) i_sram_bank (
    .clk_i,
    .arst_n_i,
    .bus ( sram_bus.sbr )
  );

  // ----------------------------------------------------------
  // Peripherals
  // ----------------------------------------------------------
  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i,
    .arst_n_i,
    .fetch_en_i,
    .bus            ( soc_ctrl_bus.sbr ),
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_regs #(
    .GpioCount ( GpioCount )
  ) i_gpio_regs (
    .clk_i,
    .arst_n_i,
    .bus           ( gpio_bus.sbr ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o
  );

endmodule

/* testbench/croc_lite_props.sv */
// Concurrent assertions on the top-level bus handshake that are bound into the domain top level
`timescale 1ns/10ps

module croc_lite_props (
  input logic clk_i,
  input logic arst_n_i,
  input logic req_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic err_o
);

  // Number of failed assertions
  int fail_count = 0;

  // Response exactly one cycle after acceptance
  a_rsp_after_accept: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (req_i && gnt_o) |=> rvalid_o
  ) else begin
    fail_count++;
    $error("rvalid_o missing one cycle after an accepted request");
  end

  a_no_spurious_rsp: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) rvalid_o |-> $past(req_i && gnt_o)
  ) else begin
    fail_count++;
    $error("rvalid_o high without an accepted request the cycle before");
  end

  a_err_with_rvalid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) err_o |-> rvalid_o
  ) else begin
    fail_count++;
    $error("err_o high while rvalid_o is low");
  end

endmodule

bind croc_lite_domain croc_lite_props u_props (
  .clk_i    ( clk_i    ),
  .arst_n_i ( arst_n_i ),
  .req_i    ( req_i    ),
  .gnt_o    ( gnt_o    ),
  .rvalid_o ( rvalid_o ),
  .err_o    ( err_o    )
);

/* testbench/tb_croc_lite.sv */
// Testbench that replays bus operations from a pattern file against the bus domain and checks the responses
`timescale 1ns/10ps

module tb_croc_lite;

  localparam int unsigned GpioCount    = 16;
  localparam int unsigned SramNumWords = 1024;
  localparam int          RspTimeout   = 8;
  localparam int          PollLimit    = 6;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   fetch_en_i;
  logic                   req_i;
  croc_lite_pkg::addr_t   addr_i;
  logic                   we_i;
  croc_lite_pkg::be_t     be_i;
  croc_lite_pkg::data_t   wdata_i;
  logic [GpioCount-1:0]   gpio_i;
  logic                   gnt_o;
  logic                   rvalid_o;
  croc_lite_pkg::data_t   rdata_o;
  logic                   err_o;
  croc_lite_pkg::addr_t   boot_addr_o;
  logic                   fetch_enable_o;
  logic [GpioCount-1:0]   gpio_o;
  logic [GpioCount-1:0]   gpio_out_en_o;

  // Pattern columns with one entry per operation
  int                     pat_test [$];
  logic [63:0]            pat_op [$];
  croc_lite_pkg::addr_t   pat_addr [$];
  croc_lite_pkg::data_t   pat_wdata [$];
  croc_lite_pkg::be_t     pat_be [$];
  croc_lite_pkg::data_t   pat_exp [$];
  logic                   pat_err [$];

  int check_count;
  int error_count;
  int test_checks;
  int test_errors;
  int test_count;

  croc_lite_domain #(
    .GpioCount    ( GpioCount    ),
    .SramNumWords ( SramNumWords )
  ) u_dut (
    .clk_i,
    .arst_n_i,
    .fetch_en_i,
    .req_i,
    .addr_i,
    .we_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .boot_addr_o,
    .fetch_enable_o,
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o
  );

  always begin
    clk_i = 1'b0;
    #10;
    clk_i = 1'b1;
    #10;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    check_count++;
    test_checks++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic bus_access(input croc_lite_pkg::addr_t addr, input logic we,
                            input croc_lite_pkg::be_t be, input croc_lite_pkg::data_t wdata,
                            output croc_lite_pkg::data_t rdata, output logic err);
    int waited;
    waited  = 0;
    req_i   = 1'b1;
    addr_i  = addr;
    we_i    = we;
    be_i    = be;
    wdata_i = wdata;
    @(negedge clk_i);
    compare_value(gnt_o, 1'b1, "gnt_o");
    req_i = 1'b0;
    while (rvalid_o !== 1'b1 && waited < RspTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (rvalid_o !== 1'b1) begin
      error_count++;
      test_errors++;
      $display("Timeout: no response on rvalid_o for the access to address %h", addr);
    end else begin
      compare_value(waited, 0, "extra cycles before rvalid_o");
    end
    rdata = rdata_o;
    err   = err_o;
  endtask

  // Reads on consecutive cycles with each response due one cycle later
  task automatic run_burst(input int lo, input int hi);
    for (int k = lo; k <= hi + 1; k++) begin
      if (k > lo) begin
        compare_value(gnt_o, 1'b1, "burst gnt_o");
        compare_value(rvalid_o, 1'b1, "burst rvalid_o");
        compare_value(rdata_o, pat_exp[k-1], "burst rdata_o");
        compare_value(err_o, pat_err[k-1], "burst err_o");
      end
      if (k <= hi) begin
        req_i   = 1'b1;
        we_i    = 1'b0;
        addr_i  = pat_addr[k];
        be_i    = pat_be[k];
        wdata_i = '0;
        @(negedge clk_i);
      end else begin
        req_i = 1'b0;
      end
    end
  endtask

  task automatic run_single(input int i);
    croc_lite_pkg::data_t rdata;
    croc_lite_pkg::data_t pin_val;
    logic                 err;
    int                   polls;
    case (pat_op[i])
      "W": begin
        bus_access(pat_addr[i], 1'b1, pat_be[i], pat_wdata[i], rdata, err);
        compare_value(err, pat_err[i], "write err_o");
        // Write data is only defined on an error response
        if (pat_err[i]) begin
          compare_value(rdata, pat_exp[i], "write rdata_o");
        end
      end
      "R": begin
        bus_access(pat_addr[i], 1'b0, pat_be[i], '0, rdata, err);
        compare_value(rdata, pat_exp[i], "read rdata_o");
        compare_value(err, pat_err[i], "read err_o");
      end
      "F": begin
        fetch_en_i = pat_wdata[i][0];
        @(negedge clk_i);
        compare_value(fetch_enable_o, pat_exp[i], "fetch_enable_o");
      end
      "A": compare_value(boot_addr_o, pat_exp[i], "boot_addr_o");
      "P": compare_value({gpio_out_en_o, gpio_o}, pat_exp[i], "gpio_out_en_o and gpio_o");
      "G": begin
        pin_val = $urandom;
        pin_val = pin_val & ((32'd1 << GpioCount) - 32'd1);
        gpio_i  = pin_val[GpioCount-1:0];
        polls   = 0;
        bus_access(pat_addr[i], 1'b0, 4'hf, '0, rdata, err);
        while (rdata !== pin_val && polls < PollLimit) begin
          bus_access(pat_addr[i], 1'b0, 4'hf, '0, rdata, err);
          polls++;
        end
        if (rdata !== pin_val) begin
          $display("Timeout: gpio_i value %h never appeared in the GPIO input register", pin_val);
        end
        compare_value(rdata, pin_val, "gpio input readback");
      end
      default: begin
        error_count++;
        test_errors++;
        $display("Unknown operation in the pattern file for test %0d", pat_test[i]);
      end
    endcase
  endtask

  task automatic report_test(input int num);
    test_count++;
    $display("Test %0d finished: %0d checks, %0d errors", num, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int                   fd;
    int                   n;
    int                   ch;
    int                   idx;
    int                   last;
    int                   cur_test;
    int                   t_num;
    logic [63:0]          t_op;
    croc_lite_pkg::addr_t t_addr;
    croc_lite_pkg::data_t t_wdata;
    croc_lite_pkg::be_t   t_be;
    croc_lite_pkg::data_t t_exp;
    logic                 t_err;

    void'($urandom(43097));
    arst_n_i    = 1'b0;
    fetch_en_i  = 1'b0;
    req_i       = 1'b0;
    addr_i      = '0;
    we_i        = 1'b0;
    be_i        = '0;
    wdata_i     = '0;
    gpio_i      = '0;
    check_count = 0;
    error_count = 0;
    test_checks = 0;
    test_errors = 0;
    test_count  = 0;

    fd = $fopen("testbench/bus_patterns.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the pattern file testbench/bus_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%d %s %h %h %h %h %h", t_num, t_op, t_addr, t_wdata, t_be, t_exp,
                    t_err);
        if (n == 7) begin
          pat_test.push_back(t_num);
          pat_op.push_back(t_op);
          pat_addr.push_back(t_addr);
          pat_wdata.push_back(t_wdata);
          pat_be.push_back(t_be);
          pat_exp.push_back(t_exp);
          pat_err.push_back(t_err);
        end else begin
          // Skip the rest of a comment line
          ch = 0;
          while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
          end
        end
      end
      $fclose(fd);
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    // Idle outputs out of reset
    compare_value(rvalid_o, 1'b0, "rvalid_o after reset");
    compare_value(err_o, 1'b0, "err_o after reset");
    compare_value({gpio_out_en_o, gpio_o}, '0, "gpio_out_en_o and gpio_o after reset");

    idx      = 0;
    cur_test = (pat_test.size() > 0) ? pat_test[0] : 0;
    while (idx < pat_test.size()) begin
      if (pat_test[idx] != cur_test) begin
        report_test(cur_test);
        cur_test = pat_test[idx];
      end
      if (pat_op[idx] == "B") begin
        last = idx;
        while (last + 1 < pat_test.size() && pat_op[last+1] == "B" &&
               pat_test[last+1] == cur_test) begin
          last++;
        end
        run_burst(idx, last);
        idx = last + 1;
      end else begin
        run_single(idx);
        idx++;
      end
    end
    if (pat_test.size() > 0) begin
      report_test(cur_test);
    end

    error_count += u_dut.u_props.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/bus_patterns.txt */
# test op addr wdata be exp_rdata exp_err, all hex except the test number
# ops: W write, R read, F drive fetch_en_i, A boot_addr_o, P {gpio_out_en_o, gpio_o}, G gpio_i poll, B burst read
1 W 10000010 11223344 f 00000000 0
1 W 10000010 aabbccdd 5 00000000 0
1 R 10000010 00000000 f 11bb33dd 0
2 A 00000000 00000000 0 10000000 0
2 W 03000000 20000080 f 00000000 0
2 A 00000000 00000000 0 20000080 0
2 R 03000000 00000000 f 20000080 0
2 F 00000000 00000000 0 00000000 0
2 F 00000000 00000001 0 00000001 0
2 W 03000004 00000001 1 00000000 0
2 F 00000000 00000000 0 00000001 0
2 F 00000000 00000001 0 00000001 0
2 R 03000004 00000000 f 00000001 0
2 F 00000000 00000000 0 00000001 0
3 W 03005000 0000a5f0 3 00000000 0
3 W 03005004 00003c5a 3 00000000 0
3 P 00000000 00000000 0 a5f03c5a 0
3 G 03005008 00000000 f 00000000 0
4 R 20000000 00000000 f badcab1e 1
4 W 00000000 12345678 f badcab1e 1
4 R 03001000 00000000 f badcab1e 1
4 R 0300000c 00000000 f 00000000 0
4 R 03005010 00000000 f 00000000 0
5 B 10000010 00000000 f 11bb33dd 0
5 B 03000000 00000000 f 20000080 0
5 B 40000000 00000000 f badcab1e 1
5 B 03005004 00000000 f 00003c5a 0

/* sources.f */
src/croc_lite_pkg.sv
src/obi_bus_if.sv
src/bus_demux.sv
src/sram_bank.sv
src/soc_ctrl_regs.sv
src/gpio_regs.sv
src/croc_lite_domain.sv
testbench/croc_lite_props.sv
testbench/tb_croc_lite.sv

/* Bender.yml */
package:
  name: croc_lite

sources:
  - files:
      - src/croc_lite_pkg.sv
      - src/obi_bus_if.sv
      - src/bus_demux.sv
      - src/sram_bank.sv
      - src/soc_ctrl_regs.sv
      - src/gpio_regs.sv
      - src/croc_lite_domain.sv
  - target: test
    files:
      - testbench/croc_lite_props.sv
      - testbench/tb_croc_lite.sv
